// ==== build.f ====
npc_pkg.sv
npc_ifu.sv
npc_idu.sv
npc_exu.sv
npc_regfile.sv
npc_top.sv
tb_npc.sv

// ==== npc_exu.sv ====
`timescale 1ns/1ps

module npc_exu
    import npc_pkg::*;
(
    input  npc_op_t         op,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] imm,
    input  logic            exec_en,
    output logic [XLEN-1:0] result,
    output logic [XLEN-1:0] next_pc,
    output logic            reg_wen,
    output logic            halt_req,
    output logic            illegal_req
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] rs1_plus_imm;
    logic            writes_rd;

    // Shared adders
    assign pc_plus4     = pc + 32'd4;
    assign rs1_plus_imm = rs1_data + imm;

    // ------------------------------
    // Result and next PC
    // ------------------------------

    always_comb begin
        result    = '0;
        next_pc   = pc_plus4;
        writes_rd = 1'b0;
        case (op)
            OP_ADDI: begin
                result    = rs1_plus_imm;
                writes_rd = 1'b1;
            end
            OP_JALR: begin
                // Link address, target with bit 0 cleared
                result    = pc_plus4;
                next_pc   = {rs1_plus_imm[XLEN-1:1], 1'b0};
                writes_rd = 1'b1;
            end
            OP_LUI: begin
                result    = imm;
                writes_rd = 1'b1;
            end
            OP_AUIPC: begin
                result    = pc + imm;
                writes_rd = 1'b1;
            end
            default: begin
                // ebreak and illegal, no write back
                writes_rd = 1'b0;
            end
        endcase
    end

    // Side effects only in the execute cycle
    assign reg_wen     = exec_en && writes_rd;
    assign halt_req    = exec_en && (op == OP_EBREAK);
    assign illegal_req = exec_en && (op == OP_ILLEGAL);

endmodule

// ==== npc_idu.sv ====
`timescale 1ns/1ps

module npc_idu
    import npc_pkg::*;
(
    input  logic [XLEN-1:0] inst,
    output npc_op_t         op,
    output logic [4:0]      rd,
    output logic [4:0]      rs1,
    output logic [XLEN-1:0] imm
);

    // Major opcodes of the kept subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    // Full ebreak word
    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;

    // ------------------------------
    // Field extraction
    // ------------------------------

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];

    // I-type, sign extended from bit 31
    assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
    // U-type, low 12 bits zero
    assign imm_u = {inst[31:12], 12'b0};

    // ------------------------------
    // Operation decode
    // ------------------------------

    always_comb begin
        op  = OP_ILLEGAL;
        imm = '0;
        if (inst == INST_EBREAK) begin
            op = OP_EBREAK;
        end else if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin
            op  = OP_ADDI;
            imm = imm_i;
        end else if (opcode == OPC_JALR && funct3 == 3'b000) begin
            op  = OP_JALR;
            imm = imm_i;
        end else if (opcode == OPC_LUI) begin
            op  = OP_LUI;
            imm = imm_u;
        end else if (opcode == OPC_AUIPC) begin
            op  = OP_AUIPC;
            imm = imm_u;
        end
        // Everything else stays illegal
    end

endmodule

// ==== npc_ifu.sv ====
`timescale 1ns/1ps

module npc_ifu
    import npc_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_ack,
    input  logic [XLEN-1:0] imem_rdata,
    output logic            imem_req,
    output logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] pc,
    output logic            exec_en,
    input  logic [XLEN-1:0] next_pc,
    input  logic            halt_req,
    input  logic            illegal_req,
    output logic            halt,
    output logic            illegal
);

    fetch_state_t    state;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;
    logic            req_q;
    logic            illegal_q;

    // ------------------------------
    // Fetch / execute sequencer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_REQ;
            req_q     <= 1'b0;
            pc_q      <= RESET_PC;
            illegal_q <= 1'b0;
        end else begin
            case (state)
                S_REQ: begin
                    // Raise req only once the last ack is gone
                    if (!req_q && !imem_ack) begin
                        req_q <= 1'b1;
                    end else if (req_q && imem_ack) begin
                        // Word captured below, drop req
                        req_q <= 1'b0;
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    // Wait for memory to close the handshake
                    if (!imem_ack) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    // Commit edge
                    pc_q <= next_pc;
                    if (halt_req || illegal_req) begin
                        state     <= S_HALT;
                        illegal_q <= illegal_req;
                    end else begin
                        // Ack is already low here, so req can go straight up
                        state <= S_REQ;
                        req_q <= 1'b1;
                    end
                end
                S_HALT: begin
                    // Parked until reset
                    state <= S_HALT;
                end
            endcase
        end
    end

    // Instruction word latched at the ack phase
    always_ff @(posedge clk) begin
        if (state == S_REQ && req_q && imem_ack) begin
            inst_q <= imem_rdata;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign imem_req  = req_q;
    assign imem_addr = pc_q;
    assign inst      = inst_q;
    assign pc        = pc_q;
    assign exec_en   = (state == S_EXEC);
    assign halt      = (state == S_HALT);
    assign illegal   = illegal_q;

    // Four-phase rule, new req only after previous ack fell
    a_req_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(imem_req) |-> !imem_ack);

    // Fetch address always word aligned
    a_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_req |-> (imem_addr[1:0] == 2'b00));

endmodule

// ==== npc_pkg.sv ====
package npc_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Data and address width
    parameter int XLEN = 32;

    // ------------------------------
    // Decoded operations
    // ------------------------------

    // Operation seen by the execute unit
    typedef enum logic [2:0] {
        OP_ADDI,
        OP_JALR,
        OP_LUI,
        OP_AUIPC,
        OP_EBREAK,
        // Anything outside the kept subset
        OP_ILLEGAL
    } npc_op_t;

    // ------------------------------
    // Fetch sequencer states
    // ------------------------------

    // One instruction in flight at a time
    typedef enum logic [1:0] {
        // Request raised, waiting for ack
        S_REQ,
        // Request dropped, waiting for ack to fall
        S_RELEASE,
        // Single execute and commit cycle
        S_EXEC,
        // Parked after ebreak or illegal encoding
        S_HALT
    } fetch_state_t;

endpackage

// ==== npc_regfile.sv ====
`timescale 1ns/1ps

module npc_regfile
    import npc_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            wen,
    input  logic [4:0]      waddr,
    input  logic [XLEN-1:0] wdata,
    input  logic [4:0]      raddr,
    output logic [XLEN-1:0] rdata,
    output logic [XLEN-1:0] a0
);

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            // Writes to x0 dropped here
            regs[waddr] <= wdata;
        end
    end

    // Combinational read
    assign rdata = (raddr == 5'd0) ? '0 : regs[raddr];

    // Trap code source, x10
    assign a0 = regs[10];

endmodule

// ==== npc_top.sv ====
`timescale 1ns/1ps

module npc_top
    import npc_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_ack,
    input  logic [XLEN-1:0] imem_rdata,
    output logic            imem_req,
    output logic [XLEN-1:0] imem_addr,
    output logic            commit_valid,
    output logic [XLEN-1:0] commit_pc,
    output logic [4:0]      commit_rd,
    output logic [XLEN-1:0] commit_data,
    output logic            commit_wen,
    output logic            halt,
    output logic            illegal,
    output logic [XLEN-1:0] halt_code
);

    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic            exec_en;
    npc_op_t         op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] next_pc;
    logic            reg_wen;
    logic            halt_req;
    logic            illegal_req;
    logic [XLEN-1:0] a0;

    // ------------------------------
    // Core blocks
    // ------------------------------

    npc_ifu #(
        .RESET_PC (RESET_PC)
    ) u_ifu (
        .clk         (clk),
        .reset       (reset),
        .imem_ack    (imem_ack),
        .imem_rdata  (imem_rdata),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .inst        (inst),
        .pc          (pc),
        .exec_en     (exec_en),
        .next_pc     (next_pc),
        .halt_req    (halt_req),
        .illegal_req (illegal_req),
        .halt        (halt),
        .illegal     (illegal)
    );

    npc_idu u_idu (
        .inst (inst),
        .op   (op),
        .rd   (rd),
        .rs1  (rs1),
        .imm  (imm)
    );

    npc_exu u_exu (
        .op          (op),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .imm         (imm),
        .exec_en     (exec_en),
        .result      (result),
        .next_pc     (next_pc),
        .reg_wen     (reg_wen),
        .halt_req    (halt_req),
        .illegal_req (illegal_req)
    );

    npc_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .wen   (reg_wen),
        .waddr (rd),
        .wdata (result),
        .raddr (rs1),
        .rdata (rs1_data),
        .a0    (a0)
    );

    // Commit trace, one pulse per retired instruction
    assign commit_valid = exec_en;
    assign commit_pc    = pc;
    assign commit_rd    = rd;
    assign commit_data  = result;
    assign commit_wen   = reg_wen;

    // Trap code shown from a0
    assign halt_code = a0;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the NPC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_npc --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_npc 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// ==== tb_npc.sv ====
`timescale 1ns/1ps

module tb_npc;

    localparam logic [31:0] RESET_PC = 32'h8000_0000;
    localparam logic [31:0] EBREAK   = 32'h0010_0073;
    // add a0, a0, a1, an R-type outside the subset
    localparam logic [31:0] ADD_R    = 32'h00B5_0533;
    localparam int DEPTH   = 64;
    localparam int TIMEOUT = 1000;

    logic            clk;
    logic            reset;
    logic            imem_ack = 1'b0;
    logic [31:0]     imem_rdata = 32'd0;
    logic            imem_req;
    logic [31:0]     imem_addr;
    logic            commit_valid;
    logic [31:0]     commit_pc;
    logic [4:0]      commit_rd;
    logic [31:0]     commit_data;
    logic            commit_wen;
    logic            halt;
    logic            illegal;
    logic [31:0]     halt_code;

    logic [31:0] prog [0:DEPTH-1];
    logic [31:0] rng_state = 32'd53;
    logic [1:0]  wait_cnt = 2'd0;

    // Captured commit trace
    logic [31:0] mon_pc [0:15];
    logic [31:0] mon_data [0:15];
    logic [4:0]  mon_rd [0:15];
    logic        mon_wen [0:15];
    int          n_commits = 0;
    int          n_checks = 0;
    int          n_errors = 0;

    // Fetch addresses in the order served
    logic [31:0] mon_addr [0:15];
    int          n_fetches = 0;

    npc_top #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_wen   (commit_wen),
        .halt         (halt),
        .illegal      (illegal),
        .halt_code    (halt_code)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Instruction memory model
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Outside the program, the word is its own address, low bits 00 so never legal
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_PC;
        if (off < 32'(DEPTH * 4)) begin
            return prog[off[7:2]];
        end
        return addr;
    endfunction

    // Each phase answered after 0..3 idle cycles
    always @(posedge clk) begin
        if (reset) begin
            imem_ack  <= 1'b0;
            wait_cnt  <= 2'd0;
            n_fetches <= 0;
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (imem_req && !imem_ack) begin
            imem_ack   <= 1'b1;
            imem_rdata <= fetch_word(imem_addr);
            rng_state  <= xorshift32(rng_state);
            wait_cnt   <= rng_state[1:0];
            if (n_fetches < 16) begin
                mon_addr[n_fetches] <= imem_addr;
            end
            n_fetches <= n_fetches + 1;
        end else if (!imem_req && imem_ack) begin
            imem_ack  <= 1'b0;
            rng_state <= xorshift32(rng_state);
            wait_cnt  <= rng_state[1:0];
        end
    end

    // Commit monitor
    always @(posedge clk) begin
        if (reset) begin
            n_commits <= 0;
        end else if (commit_valid && n_commits < 16) begin
            mon_pc[n_commits]   <= commit_pc;
            mon_rd[n_commits]   <= commit_rd;
            mon_data[n_commits] <= commit_data;
            mon_wen[n_commits]  <= commit_wen;
            n_commits <= n_commits + 1;
        end
    end

    // ------------------------------
    // Encoders and helpers
    // ------------------------------

    function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_jalr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_auipc(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], 7'b0010111};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %08h expected %08h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    // Data only compared on writing commits
    task automatic expect_commit(input int idx, input logic [31:0] exp_pc, input int exp_rd,
                                 input logic [31:0] exp_data, input logic exp_wen);
        if (idx >= n_commits) begin
            $display("Commit %0d never happened, only %0d seen", idx, n_commits);
            n_errors++;
        end else begin
            check_value($sformatf("commit %0d pc", idx), mon_pc[idx], exp_pc);
            // Instruction was fetched from its own pc
            check_value($sformatf("commit %0d fetch addr", idx), mon_addr[idx], exp_pc);
            check_value($sformatf("commit %0d rd", idx), {27'd0, mon_rd[idx]}, 32'(exp_rd));
            check_value($sformatf("commit %0d wen", idx), {31'd0, mon_wen[idx]},
                        {31'd0, exp_wen});
            if (exp_wen) begin
                check_value($sformatf("commit %0d data", idx), mon_data[idx], exp_data);
            end
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < DEPTH; i++) begin
            prog[i] = RESET_PC + 32'(i * 4);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_halt(input string tname);
        int cycles;
        cycles = 0;
        while (!halt && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("%s: core did not halt within %0d cycles", tname, cycles);
            n_errors++;
        end
    endtask

    // Counts cycles with a fetch request while parked
    task automatic watch_idle(input int cycles, output int req_seen);
        req_seen = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (imem_req !== 1'b0) begin
                req_seen++;
            end
        end
    endtask

    task automatic end_test(input string tname, input int err_start);
        $display("test %s: %0d errors", tname, n_errors - err_start);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_addi_chain();
        int e0;
        e0 = n_errors;
        clear_program();
        prog[0] = enc_addi(1, 0, 5);
        prog[1] = enc_addi(2, 1, -3);
        prog[2] = enc_addi(3, 2, -100);
        prog[3] = enc_addi(10, 3, 0);
        prog[4] = EBREAK;
        apply_reset();
        wait_halt("addi_chain");
        check_value("addi_chain commit count", n_commits, 5);
        // PC steps by 4 per commit
        expect_commit(0, RESET_PC, 1, 5, 1'b1);
        expect_commit(1, RESET_PC + 4, 2, 2, 1'b1);
        expect_commit(2, RESET_PC + 8, 3, -98, 1'b1);
        expect_commit(3, RESET_PC + 12, 10, -98, 1'b1);
        expect_commit(4, RESET_PC + 16, 0, 0, 1'b0);
        end_test("addi_chain", e0);
    endtask

    task automatic test_lui_auipc();
        int e0;
        e0 = n_errors;
        clear_program();
        prog[0] = enc_lui(5, 20'h12345);
        prog[1] = enc_auipc(6, 20'h00010);
        prog[2] = enc_lui(7, 20'hFFFFF);
        prog[3] = EBREAK;
        apply_reset();
        wait_halt("lui_auipc");
        check_value("lui_auipc commit count", n_commits, 4);
        expect_commit(0, RESET_PC, 5, 32'h1234_5000, 1'b1);
        expect_commit(1, RESET_PC + 4, 6, RESET_PC + 4 + 32'h0001_0000, 1'b1);
        expect_commit(2, RESET_PC + 8, 7, 32'hFFFF_F000, 1'b1);
        end_test("lui_auipc", e0);
    endtask

    task automatic test_jalr();
        int          e0;
        logic [31:0] base;
        logic [31:0] target;
        e0 = n_errors;
        base = {RESET_PC[31:12], 12'd0};
        // Odd sum, bit 0 dropped, lands on word 4
        target = (base + 32'd17) & ~32'd1;
        clear_program();
        prog[0] = enc_lui(1, RESET_PC[31:12]);
        prog[1] = enc_jalr(2, 1, 17);
        prog[4] = enc_addi(3, 2, 1);
        prog[5] = EBREAK;
        apply_reset();
        wait_halt("jalr");
        check_value("jalr commit count", n_commits, 4);
        expect_commit(0, RESET_PC, 1, base, 1'b1);
        expect_commit(1, RESET_PC + 4, 2, RESET_PC + 8, 1'b1);
        expect_commit(2, target, 3, RESET_PC + 9, 1'b1);
        expect_commit(3, target + 4, 0, 0, 1'b0);
        end_test("jalr", e0);
    endtask

    task automatic test_x0_write();
        int e0;
        e0 = n_errors;
        clear_program();
        prog[0] = enc_addi(0, 0, 77);
        prog[1] = enc_addi(4, 0, 9);
        prog[2] = EBREAK;
        apply_reset();
        wait_halt("x0_write");
        check_value("x0_write commit count", n_commits, 3);
        // Attempt is visible on the trace
        expect_commit(0, RESET_PC, 0, 77, 1'b1);
        // x0 still reads zero
        expect_commit(1, RESET_PC + 4, 4, 9, 1'b1);
        end_test("x0_write", e0);
    endtask

    task automatic test_ebreak();
        int e0;
        int req_seen;
        e0 = n_errors;
        clear_program();
        prog[0] = enc_addi(10, 0, 32'h5A5);
        prog[1] = EBREAK;
        apply_reset();
        wait_halt("ebreak");
        check_value("ebreak halt", {31'd0, halt}, 32'd1);
        check_value("ebreak illegal", {31'd0, illegal}, 32'd0);
        check_value("ebreak halt_code", halt_code, 32'h5A5);
        expect_commit(1, RESET_PC + 4, 0, 0, 1'b0);
        watch_idle(20, req_seen);
        check_value("ebreak req cycles after halt", req_seen, 0);
        check_value("ebreak commit count", n_commits, 2);
        end_test("ebreak", e0);
    endtask

    task automatic test_illegal();
        int e0;
        int req_seen;
        e0 = n_errors;
        clear_program();
        prog[0] = enc_addi(10, 0, 3);
        prog[1] = ADD_R;
        // Must never execute
        prog[2] = enc_addi(11, 0, 1);
        apply_reset();
        wait_halt("illegal");
        check_value("illegal flag", {31'd0, illegal}, 32'd1);
        check_value("illegal halt", {31'd0, halt}, 32'd1);
        expect_commit(1, RESET_PC + 4, 10, 0, 1'b0);
        watch_idle(20, req_seen);
        check_value("illegal req cycles after halt", req_seen, 0);
        check_value("illegal fetch count", n_fetches, 2);
        check_value("illegal commit count", n_commits, 2);
        end_test("illegal", e0);
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------

    initial begin
        reset = 1'b1;
        test_addi_chain();
        test_lui_auipc();
        test_jalr();
        test_x0_write();
        test_ebreak();
        test_illegal();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
